// ==== src/rapcore_pkg.sv ====
package rapcore_pkg;

  // Host words are 64 bits, MSB first on the wire
  parameter int WORD_BITS = 64;

  // Command header sits in the top byte of the first word
  parameter int HEADER_BITS = 8;

  // Command codes
  parameter logic [HEADER_BITS-1:0] CMD_COORDINATED_STEP = 8'h01;
  parameter logic [HEADER_BITS-1:0] CMD_MOTOR_ENABLE     = 8'h0A;
  parameter logic [HEADER_BITS-1:0] CMD_CLK_DIVISOR      = 8'h14;
  parameter logic [HEADER_BITS-1:0] CMD_API_VERSION      = 8'hFE;

  // Version bytes for the API version reply
  parameter logic [7:0] VERSION_MAJOR = 8'd0;
  parameter logic [7:0] VERSION_MINOR = 8'd1;
  parameter logic [7:0] VERSION_PATCH = 8'd0;

  // DDA tick period in CLK cycles after reset
  // 40 gives a 400 kHz tick at 16 MHz
  parameter logic [7:0] DEFAULT_CLOCK_DIVISOR = 8'd40;

  // Data words after a move header
  // Duration, increment, incrementincrement
  parameter int MOVE_WORDS = 3;

  // One SPI word, two views
  // First word of a message is read as a header,
  // the words that follow are read as plain data
  typedef union packed {
    // Whole word, used for move data
    logic [WORD_BITS-1:0] raw;
    // Header in the top byte, arguments below
    struct packed {
      logic [HEADER_BITS-1:0]           header;
      logic [WORD_BITS-HEADER_BITS-1:0] payload;
    } cmd;
  } rap_word_u;

endpackage

// ==== src/spi_word.sv ====
`timescale 1ns/1ns

module spi_word (
  input  logic                                 CLK,
  input  logic                                 resetn,
  input  logic                                 SCK,
  input  logic                                 CS,
  input  logic                                 COPI,
  output logic                                 CIPO,
  input  logic [rapcore_pkg::WORD_BITS-1:0]    reply_data,
  output logic                                 word_received,
  output rapcore_pkg::rap_word_u               word_data
);

  // Two sync flops plus one history flop for edge detection
  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] copi_q;

  logic sck_rise;
  logic sck_fall;
  logic cs_fall;
  logic cs_rise;
  logic cs_low;

  // Bits seen in the current word
  logic [5:0] bit_count;

  // Receive shifter holds the first 63 bits, the 64th comes straight from the pin
  logic [rapcore_pkg::WORD_BITS-2:0] rx_shift;
  logic [rapcore_pkg::WORD_BITS-1:0] tx_shift;

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_fall  = ~cs_q[1] & cs_q[2];
  assign cs_rise  = cs_q[1] & ~cs_q[2];
  assign cs_low   = ~cs_q[1];

  // MSB of the transmit shifter is the pin
  assign CIPO = tx_shift[rapcore_pkg::WORD_BITS-1];

  // Pin synchronizers, CS idles high
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q  <= 3'b000;
      cs_q   <= 3'b111;
      copi_q <= 2'b00;
    end else begin
      sck_q  <= {sck_q[1:0], SCK};
      cs_q   <= {cs_q[1:0], CS};
      copi_q <= {copi_q[0], COPI};
    end
  end

  // Bit counter, strobe and transmit shifter
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_count     <= '0;
      word_received <= 1'b0;
      tx_shift      <= '0;
    end else begin
      word_received <= 1'b0;
      if (cs_fall) begin
        // Reply computed for the previous word goes out now
        bit_count <= '0;
        tx_shift  <= reply_data;
      end else if (cs_rise) begin
        // Partial word is dropped
        bit_count <= '0;
      end else if (cs_low && sck_rise) begin
        bit_count <= bit_count + 6'd1;
        if (bit_count == 6'd63) begin
          word_received <= 1'b1;
        end
      end else if (cs_low && sck_fall) begin
        // Mode 0, next bit presented after falling edge
        tx_shift <= {tx_shift[rapcore_pkg::WORD_BITS-2:0], 1'b0};
      end
    end
  end

  // Receive path
  always_ff @(posedge CLK) begin
    if (cs_low && sck_rise) begin
      rx_shift <= {rx_shift[rapcore_pkg::WORD_BITS-3:0], copi_q[1]};
      if (bit_count == 6'd63) begin
        word_data.raw <= {rx_shift, copi_q[1]};
      end
    end
  end

endmodule

// ==== src/command_decoder.sv ====
`timescale 1ns/1ns

module command_decoder (
  input  logic                                     CLK,
  input  logic                                     resetn,
  input  logic                                     word_received,
  input  rapcore_pkg::rap_word_u                   word_data,
  input  logic signed [rapcore_pkg::WORD_BITS-1:0] encoder_count,
  output logic [rapcore_pkg::WORD_BITS-1:0]        reply_data,
  output logic                                     ENABLE,
  output logic [7:0]                               clock_divisor,
  output logic                                     move_write,
  output logic                                     move_dir,
  output logic [rapcore_pkg::WORD_BITS-1:0]        move_duration,
  output logic [rapcore_pkg::WORD_BITS-1:0]        move_increment,
  output logic [rapcore_pkg::WORD_BITS-1:0]        move_incrementincrement
);

  // Data word order inside a move message
  localparam logic [1:0] DURATION_WORD  = 2'd0;
  localparam logic [1:0] INCREMENT_WORD = 2'd1;
  localparam logic [1:0] LAST_DATA_WORD = 2'(rapcore_pkg::MOVE_WORDS - 1);

  // Header of the message in progress
  logic [rapcore_pkg::HEADER_BITS-1:0] message_header;
  // Data words already taken for the move
  logic [1:0]                          word_count;
  logic                                awaiting_data;
  // Encoder position latched at the move header
  logic [rapcore_pkg::WORD_BITS-1:0]   encoder_store;

  // Only the move command spans more than one word
  assign awaiting_data = (message_header == rapcore_pkg::CMD_COORDINATED_STEP);

  // Message state, configuration and replies
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      message_header <= '0;
      word_count     <= '0;
      reply_data     <= '0;
      ENABLE         <= 1'b0;
      clock_divisor  <= rapcore_pkg::DEFAULT_CLOCK_DIVISOR;
      move_write     <= 1'b0;
    end else begin
      move_write <= 1'b0;
      if (word_received) begin
        // Nothing to say unless this word asks for it
        reply_data <= '0;
        if (!awaiting_data) begin
          // Header word
          message_header <= word_data.cmd.header;
          word_count     <= '0;
          case (word_data.cmd.header)
            rapcore_pkg::CMD_MOTOR_ENABLE: begin
              ENABLE <= word_data.cmd.payload[0];
            end
            rapcore_pkg::CMD_CLK_DIVISOR: begin
              clock_divisor <= word_data.cmd.payload[7:0];
            end
            rapcore_pkg::CMD_API_VERSION: begin
              reply_data <= {{(rapcore_pkg::WORD_BITS-24){1'b0}},
                             rapcore_pkg::VERSION_MAJOR,
                             rapcore_pkg::VERSION_MINOR,
                             rapcore_pkg::VERSION_PATCH};
            end
            default: begin
              // Move header handled below, others ignored
            end
          endcase
        end else begin
          // Move data word
          word_count <= word_count + 2'd1;
          if (word_count == INCREMENT_WORD) begin
            // Host reads this during the last data word
            reply_data <= encoder_store;
          end
          if (word_count == LAST_DATA_WORD) begin
            move_write     <= 1'b1;
            message_header <= '0;
            word_count     <= '0;
          end
        end
      end
    end
  end

  // Move fields staged for the buffer
  always_ff @(posedge CLK) begin
    if (word_received) begin
      if (!awaiting_data) begin
        if (word_data.cmd.header == rapcore_pkg::CMD_COORDINATED_STEP) begin
          move_dir      <= word_data.cmd.payload[0];
          encoder_store <= encoder_count;
        end
      end else begin
        case (word_count)
          DURATION_WORD:  move_duration  <= word_data.raw;
          INCREMENT_WORD: move_increment <= word_data.raw;
          default:        move_incrementincrement <= word_data.raw;
        endcase
      end
    end
  end

endmodule

// ==== src/move_buffer.sv ====
`timescale 1ns/1ns

module move_buffer #(
  parameter int MOVE_BUFFER_DEPTH = 4
) (
  input  logic                              CLK,
  input  logic                              resetn,
  input  logic                              move_write,
  input  logic                              write_dir,
  input  logic [rapcore_pkg::WORD_BITS-1:0] write_duration,
  input  logic [rapcore_pkg::WORD_BITS-1:0] write_increment,
  input  logic [rapcore_pkg::WORD_BITS-1:0] write_incrementincrement,
  output logic                              full,
  output logic                              move_valid,
  input  logic                              move_take,
  output logic                              move_dir,
  output logic [rapcore_pkg::WORD_BITS-1:0] move_duration,
  output logic [rapcore_pkg::WORD_BITS-1:0] move_increment,
  output logic [rapcore_pkg::WORD_BITS-1:0] move_incrementincrement
);

  // Depth is a power of two so pointers wrap on their own
  localparam int ADDR_BITS = $clog2(MOVE_BUFFER_DEPTH);

  logic                              dir_mem      [MOVE_BUFFER_DEPTH];
  logic [rapcore_pkg::WORD_BITS-1:0] duration_mem [MOVE_BUFFER_DEPTH];
  logic [rapcore_pkg::WORD_BITS-1:0] inc_mem      [MOVE_BUFFER_DEPTH];
  logic [rapcore_pkg::WORD_BITS-1:0] incinc_mem   [MOVE_BUFFER_DEPTH];

  logic [ADDR_BITS-1:0] wr_ptr;
  logic [ADDR_BITS-1:0] rd_ptr;
  // One extra bit to tell full from empty
  logic [ADDR_BITS:0]   count;

  logic do_write;
  logic do_take;

  assign full       = (count == (ADDR_BITS+1)'(MOVE_BUFFER_DEPTH));
  assign move_valid = (count != '0);

  // Writes while full are lost
  assign do_write = move_write & ~full;
  assign do_take  = move_take & move_valid;

  // Oldest entry is always on the read side
  assign move_dir                = dir_mem[rd_ptr];
  assign move_duration           = duration_mem[rd_ptr];
  assign move_increment          = inc_mem[rd_ptr];
  assign move_incrementincrement = incinc_mem[rd_ptr];

  // Pointers and occupancy
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_take) rd_ptr <= rd_ptr + 1'b1;
      case ({do_write, do_take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge CLK) begin
    if (do_write) begin
      dir_mem[wr_ptr]      <= write_dir;
      duration_mem[wr_ptr] <= write_duration;
      inc_mem[wr_ptr]      <= write_increment;
      incinc_mem[wr_ptr]   <= write_incrementincrement;
    end
  end

endmodule

// ==== src/dda_timer.sv ====
`timescale 1ns/1ns

module dda_timer (
  input  logic                              CLK,
  input  logic                              resetn,
  input  logic [7:0]                        clock_divisor,
  input  logic                              HALT,
  input  logic                              move_valid,
  input  logic                              move_dir,
  input  logic [rapcore_pkg::WORD_BITS-1:0] move_duration,
  input  logic [rapcore_pkg::WORD_BITS-1:0] move_increment,
  input  logic [rapcore_pkg::WORD_BITS-1:0] move_incrementincrement,
  output logic                              move_take,
  output logic                              STEP,
  output logic                              DIR,
  output logic                              MOVE_DONE
);

  logic       running;
  logic [7:0] div_count;
  logic       tick;

  // Step phase, wraps once per step
  logic [rapcore_pkg::WORD_BITS-1:0] accumulator;
  logic [rapcore_pkg::WORD_BITS-1:0] increment;
  logic [rapcore_pkg::WORD_BITS-1:0] incrementincrement;
  // Ticks left in the current move
  logic [rapcore_pkg::WORD_BITS-1:0] remaining;
  // Carry out of the top bit is the step
  logic [rapcore_pkg::WORD_BITS:0]   acc_sum;

  // Divisor of 0 behaves as 1; HALT freezes the divider
  assign tick = running & ~HALT &
                (({1'b0, div_count} + 9'd1) >= {1'b0, clock_divisor});

  assign acc_sum = {1'b0, accumulator} + {1'b0, increment};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      running   <= 1'b0;
      div_count <= '0;
      move_take <= 1'b0;
      STEP      <= 1'b0;
      DIR       <= 1'b0;
      MOVE_DONE <= 1'b0;
    end else begin
      move_take <= 1'b0;
      STEP      <= 1'b0;
      MOVE_DONE <= 1'b0;
      if (!running) begin
        // Pull the next move, buffer pops on the following edge
        if (move_valid) begin
          running   <= 1'b1;
          move_take <= 1'b1;
          div_count <= '0;
          DIR       <= move_dir;
        end
      end else if (tick) begin
        div_count <= '0;
        STEP      <= acc_sum[rapcore_pkg::WORD_BITS];
        // Last tick of the move, zero length ends on the first
        if (remaining <= 64'd1) begin
          running   <= 1'b0;
          MOVE_DONE <= 1'b1;
        end
      end else if (!HALT) begin
        div_count <= div_count + 8'd1;
      end
    end
  end

  // Move datapath
  always_ff @(posedge CLK) begin
    if (!running && move_valid) begin
      accumulator        <= '0;
      increment          <= move_increment;
      incrementincrement <= move_incrementincrement;
      remaining          <= move_duration;
    end else if (tick) begin
      accumulator <= acc_sum[rapcore_pkg::WORD_BITS-1:0];
      // Second order term for acceleration
      increment   <= increment + incrementincrement;
      remaining   <= remaining - 64'd1;
    end
  end

endmodule

// ==== src/quad_encoder.sv ====
`timescale 1ns/1ns

module quad_encoder (
  input  logic                                     CLK,
  input  logic                                     resetn,
  input  logic                                     ENC_A,
  input  logic                                     ENC_B,
  output logic signed [rapcore_pkg::WORD_BITS-1:0] count
);

  // Two sync flops plus previous sample
  logic [2:0] a_q;
  logic [2:0] b_q;
  // Previous A/B then current A/B
  logic [3:0] transition;

  assign transition = {a_q[2], b_q[2], a_q[1], b_q[1]};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_q   <= 3'b000;
      b_q   <= 3'b000;
      count <= '0;
    end else begin
      a_q <= {a_q[1:0], ENC_A};
      b_q <= {b_q[1:0], ENC_B};
      case (transition)
        // Forward, A leads B: 00 -> 10 -> 11 -> 01 -> 00
        4'b0010,
        4'b1011,
        4'b1101,
        4'b0100: count <= count + 64'sd1;
        // Reverse, B leads A
        4'b0001,
        4'b0111,
        4'b1110,
        4'b1000: count <= count - 64'sd1;
        // No change, or both inputs flipped at once
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/rapcore.sv ====
`timescale 1ns/1ns

module rapcore #(
  parameter int MOVE_BUFFER_DEPTH = 4
) (
  input  logic CLK,
  input  logic resetn,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  input  logic ENC_A,
  input  logic ENC_B,
  input  logic HALT,
  output logic CIPO,
  output logic STEP,
  output logic DIR,
  output logic ENABLE,
  output logic BUFFER_DTR,
  output logic MOVE_DONE
);

  // SPI word stage to decoder
  logic                                     word_received;
  rapcore_pkg::rap_word_u                   word_data;
  logic [rapcore_pkg::WORD_BITS-1:0]        reply_data;

  // Decoder outputs
  logic [7:0]                               clock_divisor;
  logic                                     move_write;
  logic                                     wr_dir;
  logic [rapcore_pkg::WORD_BITS-1:0]        wr_duration;
  logic [rapcore_pkg::WORD_BITS-1:0]        wr_increment;
  logic [rapcore_pkg::WORD_BITS-1:0]        wr_incrementincrement;

  // Buffer head to DDA
  logic                                     full;
  logic                                     move_valid;
  logic                                     move_take;
  logic                                     rd_dir;
  logic [rapcore_pkg::WORD_BITS-1:0]        rd_duration;
  logic [rapcore_pkg::WORD_BITS-1:0]        rd_increment;
  logic [rapcore_pkg::WORD_BITS-1:0]        rd_incrementincrement;

  // Encoder position for the move reply
  logic signed [rapcore_pkg::WORD_BITS-1:0] encoder_count;

  // Host may send another move while this is high
  assign BUFFER_DTR = ~full;

  spi_word spi0 (
    .CLK(CLK), .resetn(resetn), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .reply_data(reply_data), .word_received(word_received), .word_data(word_data)
  );

  command_decoder decoder0 (
    .CLK(CLK), .resetn(resetn), .word_received(word_received), .word_data(word_data),
    .encoder_count(encoder_count), .reply_data(reply_data), .ENABLE(ENABLE),
    .clock_divisor(clock_divisor), .move_write(move_write), .move_dir(wr_dir),
    .move_duration(wr_duration), .move_increment(wr_increment),
    .move_incrementincrement(wr_incrementincrement)
  );

  move_buffer #(.MOVE_BUFFER_DEPTH(MOVE_BUFFER_DEPTH)) buffer0 (
    .CLK(CLK), .resetn(resetn), .move_write(move_write), .write_dir(wr_dir),
    .write_duration(wr_duration), .write_increment(wr_increment),
    .write_incrementincrement(wr_incrementincrement), .full(full),
    .move_valid(move_valid), .move_take(move_take), .move_dir(rd_dir),
    .move_duration(rd_duration), .move_increment(rd_increment),
    .move_incrementincrement(rd_incrementincrement)
  );

  dda_timer dda0 (
    .CLK(CLK), .resetn(resetn), .clock_divisor(clock_divisor), .HALT(HALT),
    .move_valid(move_valid), .move_dir(rd_dir), .move_duration(rd_duration),
    .move_increment(rd_increment), .move_incrementincrement(rd_incrementincrement),
    .move_take(move_take), .STEP(STEP), .DIR(DIR), .MOVE_DONE(MOVE_DONE)
  );

  quad_encoder encoder0 (
    .CLK(CLK), .resetn(resetn), .ENC_A(ENC_A), .ENC_B(ENC_B), .count(encoder_count)
  );

endmodule

// ==== verif/rapcore_sva.sv ====
`timescale 1ns/1ns

module rapcore_sva (
  input logic CLK,
  input logic resetn,
  input logic STEP,
  input logic MOVE_DONE,
  input logic ENABLE,
  input logic word_received
);

  // Step is one CLK wide
  step_pulse: assert property (@(posedge CLK) disable iff (!resetn) STEP |=> !STEP)
    else $error("STEP high for two cycles");

  done_pulse: assert property (@(posedge CLK) disable iff (!resetn) MOVE_DONE |=> !MOVE_DONE)
    else $error("MOVE_DONE high for two cycles");

  // One strobe per SPI word
  word_strobe: assert property (@(posedge CLK) disable iff (!resetn)
                                word_received |=> !word_received)
    else $error("word_received high for two cycles");

  // Outputs quiet after a reset cycle
  reset_levels: assert property (@(posedge CLK) !resetn |=> (!STEP && !MOVE_DONE && !ENABLE))
    else $error("Output not low after reset");

endmodule

bind rapcore rapcore_sva sva0 (
  .CLK(CLK), .resetn(resetn), .STEP(STEP), .MOVE_DONE(MOVE_DONE), .ENABLE(ENABLE),
  .word_received(word_received)
);

// ==== verif/rapcore_tb.sv ====
`timescale 1ns/1ns

module rapcore_tb;

  localparam int DEPTH = 4;
  // Moves use durations 1..MAX_DURATION ticks
  localparam int MAX_DURATION = 32;
  localparam longint SLOW_DIVISOR = 80;
  localparam longint FAST_DIVISOR = 20;
  localparam longint DEFAULT_DIVISOR = longint'(rapcore_pkg::DEFAULT_CLOCK_DIVISOR);

  // Worst-case run length in CLK cycles
  localparam longint SPI_WORD_CYCLES = 660;
  localparam longint SPI_WORDS = 48;
  localparam longint MOVE_CYCLES =
    MAX_DURATION * (DEFAULT_DIVISOR + SLOW_DIVISOR + (DEPTH + 2) * FAST_DIVISOR) + 64;
  localparam longint ENCODER_CYCLES = 64 * 5;
  // 100 ns period plus half again as margin
  localparam longint WATCHDOG_NS =
    (SPI_WORD_CYCLES * SPI_WORDS + MOVE_CYCLES + ENCODER_CYCLES) * 150;

  logic CLK;
  logic resetn;
  logic SCK;
  logic CS;
  logic COPI;
  logic ENC_A;
  logic ENC_B;
  logic HALT;
  logic CIPO;
  logic STEP;
  logic DIR;
  logic ENABLE;
  logic BUFFER_DTR;
  logic MOVE_DONE;

  logic [31:0] rng_state;
  int          checks;
  int          errors;

  rapcore #(.MOVE_BUFFER_DEPTH(DEPTH)) dut0 (
    .CLK(CLK), .resetn(resetn), .SCK(SCK), .CS(CS), .COPI(COPI), .ENC_A(ENC_A),
    .ENC_B(ENC_B), .HALT(HALT), .CIPO(CIPO), .STEP(STEP), .DIR(DIR), .ENABLE(ENABLE),
    .BUFFER_DTR(BUFFER_DTR), .MOVE_DONE(MOVE_DONE)
  );

  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Expected steps with no acceleration is floor(D * inc / 2^64)
  function automatic longint rule_steps(input logic [63:0] duration,
                                        input logic [63:0] increment);
    logic [127:0] product;
    product = {64'd0, duration} * {64'd0, increment};
    return longint'(product[127:64]);
  endfunction

  function automatic rapcore_pkg::rap_word_u make_header(input logic [7:0] header,
                                                         input logic [55:0] payload);
    rapcore_pkg::rap_word_u word;
    word.cmd.header  = header;
    word.cmd.payload = payload;
    return word;
  endfunction

  task automatic check_bit(input string name, input logic expected, input logic observed);
    checks++;
    if (observed !== expected) begin
      errors++;
      $display("[ERROR] %0t %s expected %b observed %b", $time, name, expected, observed);
    end
  endtask

  task automatic check_word(input string name, input rapcore_pkg::rap_word_u expected,
                            input rapcore_pkg::rap_word_u observed);
    checks++;
    if (observed.raw !== expected.raw) begin
      errors++;
      $display("[ERROR] %0t %s expected %h observed %h", $time, name, expected.raw,
               observed.raw);
    end
  endtask

  // Tolerance covers the one-cycle jitter in a move's length
  task automatic check_count(input string name, input longint expected,
                             input longint observed, input longint tolerance);
    checks++;
    if (observed < expected - tolerance || observed > expected + tolerance) begin
      errors++;
      $display("[ERROR] %0t %s expected %0d observed %0d", $time, name, expected, observed);
    end
  endtask

  // One 64-bit mode 0 word with SCK levels of 5 CLK cycles
  task automatic spi_transfer(input rapcore_pkg::rap_word_u tx,
                              output rapcore_pkg::rap_word_u rx);
    int i;
    rx.raw = '0;
    @(negedge CLK);
    CS = 1'b0;
    for (i = rapcore_pkg::WORD_BITS - 1; i >= 0; i--) begin
      COPI = tx.raw[i];
      repeat (5) @(negedge CLK);
      // CIPO settled since the last SCK fall
      rx.raw[i] = CIPO;
      SCK = 1'b1;
      repeat (5) @(negedge CLK);
      SCK = 1'b0;
    end
    repeat (5) @(negedge CLK);
    CS = 1'b1;
    repeat (6) @(negedge CLK);
  endtask

  // Sends a header and three data words and returns the reply to the last one
  task automatic send_move(input logic dir, input logic [63:0] duration,
                           input logic [63:0] increment, input logic [63:0] incinc,
                           output rapcore_pkg::rap_word_u snapshot);
    rapcore_pkg::rap_word_u word;
    rapcore_pkg::rap_word_u rx;
    spi_transfer(make_header(rapcore_pkg::CMD_COORDINATED_STEP, {55'd0, dir}), rx);
    word.raw = duration;
    spi_transfer(word, rx);
    word.raw = increment;
    spi_transfer(word, rx);
    word.raw = incinc;
    spi_transfer(word, snapshot);
  endtask

  // Counts STEP pulses and cycles until the given number of MOVE_DONE pulses
  task automatic wait_moves(input int moves, input longint limit, output longint steps,
                            output longint cycles);
    int     done_count;
    longint waited;
    steps = 0;
    cycles = 0;
    done_count = 0;
    waited = 0;
    while (done_count < moves && waited < limit) begin
      @(negedge CLK);
      waited++;
      if (STEP) steps++;
      if (MOVE_DONE) begin
        done_count++;
        cycles = waited;
      end
    end
    if (done_count < moves) begin
      errors++;
      $display("Timed out after %0d cycles, saw %0d of %0d MOVE_DONE pulses", waited,
               done_count, moves);
    end
  endtask

  task automatic reset_levels();
    rapcore_pkg::rap_word_u expected;
    rapcore_pkg::rap_word_u rx;
    check_bit("STEP", 1'b0, STEP);
    check_bit("MOVE_DONE", 1'b0, MOVE_DONE);
    check_bit("ENABLE", 1'b0, ENABLE);
    check_bit("DIR", 1'b0, DIR);
    check_bit("BUFFER_DTR", 1'b1, BUFFER_DTR);
    check_bit("CIPO", 1'b0, CIPO);
    // Header 0x00 is not a command
    spi_transfer(make_header(8'h00, 56'd0), rx);
    expected.raw = '0;
    check_word("first reply", expected, rx);
  endtask

  task automatic version_and_enable();
    rapcore_pkg::rap_word_u expected;
    rapcore_pkg::rap_word_u rx;
    spi_transfer(make_header(rapcore_pkg::CMD_API_VERSION, 56'd0), rx);
    spi_transfer(make_header(rapcore_pkg::CMD_MOTOR_ENABLE, 56'd1), rx);
    expected.raw = {40'd0, rapcore_pkg::VERSION_MAJOR, rapcore_pkg::VERSION_MINOR,
                    rapcore_pkg::VERSION_PATCH};
    check_word("version reply", expected, rx);
    check_bit("ENABLE", 1'b1, ENABLE);
    spi_transfer(make_header(rapcore_pkg::CMD_MOTOR_ENABLE, 56'd0), rx);
    check_bit("ENABLE", 1'b0, ENABLE);
  endtask

  task automatic single_move();
    rapcore_pkg::rap_word_u rx;
    logic [31:0] r;
    logic        dir;
    logic [63:0] duration;
    logic [63:0] increment;
    longint      steps;
    longint      cycles;
    r = next_random();
    dir = r[0];
    duration = {32'd0, next_random() % 32'd32} + 64'd1;
    increment = {next_random(), next_random()};
    // Held in HALT so the move length is timed from the release
    HALT = 1'b1;
    send_move(dir, duration, increment, 64'd0, rx);
    HALT = 1'b0;
    wait_moves(1, longint'(duration) * DEFAULT_DIVISOR * 2 + 64, steps, cycles);
    check_count("STEP pulses", rule_steps(duration, increment), steps, 0);
    check_count("move cycles", longint'(duration) * DEFAULT_DIVISOR, cycles, 1);
    check_bit("DIR", dir, DIR);
    // Same move at a slower tick
    spi_transfer(make_header(rapcore_pkg::CMD_CLK_DIVISOR, 56'(SLOW_DIVISOR)), rx);
    HALT = 1'b1;
    send_move(~dir, duration, increment, 64'd0, rx);
    HALT = 1'b0;
    wait_moves(1, longint'(duration) * SLOW_DIVISOR * 2 + 64, steps, cycles);
    check_count("STEP pulses", rule_steps(duration, increment), steps, 0);
    check_count("move cycles", longint'(duration) * SLOW_DIVISOR, cycles, 1);
    check_bit("DIR", ~dir, DIR);
    spi_transfer(make_header(rapcore_pkg::CMD_CLK_DIVISOR, 56'(FAST_DIVISOR)), rx);
  endtask

  task automatic buffer_back_pressure();
    rapcore_pkg::rap_word_u rx;
    logic [63:0] duration;
    logic [63:0] increment;
    longint      expected;
    longint      steps;
    longint      cycles;
    int          extra;
    int          m;
    expected = 0;
    HALT = 1'b1;
    // The DDA holds one frozen move and the buffer holds the rest
    for (m = 0; m <= DEPTH; m++) begin
      duration = {32'd0, next_random() % 32'd32} + 64'd1;
      increment = {next_random(), next_random()};
      expected += rule_steps(duration, increment);
      send_move(m[0], duration, increment, 64'd0, rx);
    end
    check_bit("BUFFER_DTR", 1'b0, BUFFER_DTR);
    // Dropped since the buffer is full
    send_move(1'b1, 64'd8, {next_random(), next_random()}, 64'd0, rx);
    check_bit("BUFFER_DTR", 1'b0, BUFFER_DTR);
    HALT = 1'b0;
    wait_moves(DEPTH + 1, (DEPTH + 1) * MAX_DURATION * FAST_DIVISOR * 2 + 64, steps,
               cycles);
    check_count("STEP pulses", expected, steps, 0);
    check_bit("BUFFER_DTR", 1'b1, BUFFER_DTR);
    // Long enough for the dropped move to have shown up
    extra = 0;
    repeat (MAX_DURATION * FAST_DIVISOR + 16) begin
      @(negedge CLK);
      if (MOVE_DONE) extra++;
    end
    check_count("extra MOVE_DONE", 0, longint'(extra), 0);
  endtask

  task automatic encoder_snapshot();
    rapcore_pkg::rap_word_u rx;
    logic [31:0] r;
    logic [1:0]  phase;
    longint      net;
    longint      steps;
    longint      cycles;
    int          quarters;
    int          i;
    phase = 2'd0;
    net = 0;
    // Odd count keeps the net position away from zero
    quarters = 9 + 2 * int'(next_random() % 32'd16);
    for (i = 0; i < quarters; i++) begin
      r = next_random();
      if (r[0]) begin
        phase = phase + 2'd1;
        net++;
      end else begin
        phase = phase - 2'd1;
        net--;
      end
      // Gray sequence 00, 10, 11, 01 as A leads B
      ENC_A = phase[1] ^ phase[0];
      ENC_B = phase[1];
      repeat (5) @(negedge CLK);
    end
    send_move(1'b0, 64'd1, 64'd0, 64'd0, rx);
    check_count("encoder snapshot", net, longint'(rx.raw), 0);
    wait_moves(1, FAST_DIVISOR * 2 + 64, steps, cycles);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, simulation did not finish", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rng_state = 32'h5e94_a717;
    checks = 0;
    errors = 0;
    resetn = 1'b0;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    ENC_A = 1'b0;
    ENC_B = 1'b0;
    HALT = 1'b0;
    repeat (2) @(negedge CLK);
    resetn = 1'b1;
    reset_levels();
    version_and_enable();
    single_move();
    buffer_back_pressure();
    encoder_snapshot();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== build.f ====
src/rapcore_pkg.sv
src/spi_word.sv
src/command_decoder.sv
src/move_buffer.sv
src/dda_timer.sv
src/quad_encoder.sv
src/rapcore.sv
verif/rapcore_sva.sv
verif/rapcore_tb.sv

// ==== Makefile ====
TOP := rapcore_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
